// ==== include/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_XLEN      32             // Data and address width
`define CPU_RADDR_W   5              // Register number width
`define CPU_RESET_PC  32'h0000_3000  // First fetch address

// Opcode field values
`define CPU_OP_RTYPE  6'h00
`define CPU_OP_BEQ    6'h04
`define CPU_OP_BNE    6'h05
`define CPU_OP_ADDIU  6'h09
`define CPU_OP_ORI    6'h0d
`define CPU_OP_LUI    6'h0f
`define CPU_OP_LW     6'h23
`define CPU_OP_SW     6'h2b

// Funct field values under the R-type opcode
`define CPU_FN_ADDU   6'h21
`define CPU_FN_SUBU   6'h23
`define CPU_FN_AND    6'h24
`define CPU_FN_OR     6'h25
`define CPU_FN_SLT    6'h2a

`endif

// ==== rtl/cpuPkg.sv ====
`default_nettype none
`include "cpu_cfg.svh"

package cpuPkg;

    typedef logic [`CPU_XLEN-1:0]    word_t;     // One datum or address
    typedef logic [`CPU_RADDR_W-1:0] regAddr_t;  // GPR number
    typedef logic [1:0]              stage_t;    // Tuse or Tnew in cycles

    typedef struct packed {
        logic [5:0] op;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;      // Destination of R-type
        logic [4:0] shamt;
        logic [5:0] funct;
    } rType_t;

    typedef struct packed {
        logic [5:0]  op;
        regAddr_t    rs;     // Base or first source
        regAddr_t    rt;     // Destination or second source
        logic [15:0] imm16;
    } iType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
    } instr_t;

    typedef enum logic [3:0] {
        kNop, kAddu, kSubu, kAnd, kOr, kSlt,
        kAddiu, kOri, kLui, kLw, kSw, kBeq, kBne
    } instrKind_t;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui
    } aluOp_t;

endpackage

`default_nettype wire

// ==== rtl/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module fetchStage (
    input  wire                clk,
    input  wire                rstN,
    input  wire                stall,         // Freeze PC and F/D register
    input  wire                branchTaken,   // Resolved in decode
    input  wire cpuPkg::word_t branchTarget,
    input  wire cpuPkg::word_t instRdata,     // Same-cycle IM answer
    output cpuPkg::word_t      instAddr,
    output cpuPkg::instr_t     decInstr,
    output cpuPkg::word_t      decPc
);

    cpuPkg::word_t pc;
    cpuPkg::word_t nextPc;

    assign instAddr = pc;
    assign nextPc   = branchTaken ? branchTarget : pc + 32'd4;  // Delay slot already fetched

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc       <= `CPU_RESET_PC;
            decInstr <= '0;             // All zero decodes as bubble
        end else if (!stall) begin
            pc       <= nextPc;
            decInstr <= instRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall)
            decPc <= pc;                // PC of the word in decode
    end

    // Every fetch address is a whole word
    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module decodeStage (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire                   stall,        // Send bubble to execute
    input  wire cpuPkg::instr_t   decInstr,
    input  wire cpuPkg::word_t    decPc,
    input  wire                   wbWe,
    input  wire cpuPkg::regAddr_t wbAddr,
    input  wire cpuPkg::word_t    wbData,
    input  wire                   memFwdWe,     // Loads already masked
    input  wire cpuPkg::regAddr_t memFwdAddr,
    input  wire cpuPkg::word_t    memFwdData,
    output logic                  branchTaken,
    output cpuPkg::word_t         branchTarget,
    output cpuPkg::instrKind_t    decKind,
    output cpuPkg::regAddr_t      decRs,
    output cpuPkg::regAddr_t      decRt,
    output cpuPkg::instrKind_t    exKind,
    output cpuPkg::aluOp_t        exAluOp,
    output logic                  exUseImm,
    output cpuPkg::word_t         exImm,
    output cpuPkg::word_t         exRsVal,
    output cpuPkg::word_t         exRtVal,
    output cpuPkg::regAddr_t      exRs,
    output cpuPkg::regAddr_t      exRt,
    output cpuPkg::regAddr_t      exDst,
    output logic                  exWe,
    output cpuPkg::word_t         exPc
);

    cpuPkg::word_t    regs [1:31];  // r0 reads as zero
    cpuPkg::aluOp_t   aluOp;
    cpuPkg::regAddr_t dst;
    cpuPkg::word_t    imm;
    cpuPkg::word_t    rsVal;
    cpuPkg::word_t    rtVal;
    logic             isRType;
    logic             writes;
    logic             useImm;

    function automatic cpuPkg::word_t readSrc(cpuPkg::regAddr_t a);
        if (a == '0)
            return '0;
        if (memFwdWe && memFwdAddr == a)
            return memFwdData;      // ALU result one stage ahead
        if (wbWe && wbAddr == a)
            return wbData;          // Write-through of this cycle's write
        return regs[a];
    endfunction

    always_comb begin
        decKind = cpuPkg::kNop;
        case (decInstr.rType.op)
            `CPU_OP_RTYPE: begin
                case (decInstr.rType.funct)
                    `CPU_FN_ADDU: decKind = cpuPkg::kAddu;
                    `CPU_FN_SUBU: decKind = cpuPkg::kSubu;
                    `CPU_FN_AND:  decKind = cpuPkg::kAnd;
                    `CPU_FN_OR:   decKind = cpuPkg::kOr;
                    `CPU_FN_SLT:  decKind = cpuPkg::kSlt;
                    default:      decKind = cpuPkg::kNop;  // sll 0 and unknowns
                endcase
            end
            `CPU_OP_ADDIU: decKind = cpuPkg::kAddiu;
            `CPU_OP_ORI:   decKind = cpuPkg::kOri;
            `CPU_OP_LUI:   decKind = cpuPkg::kLui;
            `CPU_OP_LW:    decKind = cpuPkg::kLw;
            `CPU_OP_SW:    decKind = cpuPkg::kSw;
            `CPU_OP_BEQ:   decKind = cpuPkg::kBeq;
            `CPU_OP_BNE:   decKind = cpuPkg::kBne;
            default:       decKind = cpuPkg::kNop;
        endcase
    end

    always_comb begin
        case (decKind)
            cpuPkg::kSubu:             aluOp = cpuPkg::aluSub;
            cpuPkg::kAnd:              aluOp = cpuPkg::aluAnd;
            cpuPkg::kOr, cpuPkg::kOri: aluOp = cpuPkg::aluOr;
            cpuPkg::kSlt:              aluOp = cpuPkg::aluSlt;
            cpuPkg::kLui:              aluOp = cpuPkg::aluLui;
            default:                   aluOp = cpuPkg::aluAdd;  // Also lw/sw address
        endcase
    end

    assign decRs   = decInstr.iType.rs;
    assign decRt   = decInstr.iType.rt;
    assign isRType = decKind inside {cpuPkg::kAddu, cpuPkg::kSubu, cpuPkg::kAnd,
                                     cpuPkg::kOr, cpuPkg::kSlt};
    assign writes  = isRType || decKind inside {cpuPkg::kAddiu, cpuPkg::kOri,
                                                cpuPkg::kLui, cpuPkg::kLw};
    assign useImm  = decKind inside {cpuPkg::kAddiu, cpuPkg::kOri, cpuPkg::kLui,
                                     cpuPkg::kLw, cpuPkg::kSw};
    assign dst     = isRType ? decInstr.rType.rd : decInstr.iType.rt;  // View by format
    assign imm     = (decKind inside {cpuPkg::kOri, cpuPkg::kLui})
                   ? cpuPkg::word_t'(decInstr.iType.imm16)             // Zero extend
                   : cpuPkg::word_t'($signed(decInstr.iType.imm16));   // Sign extend

    always_comb begin
        rsVal        = readSrc(decRs);
        rtVal        = readSrc(decRt);
        branchTaken  = (decKind == cpuPkg::kBeq && rsVal == rtVal)
                    || (decKind == cpuPkg::kBne && rsVal != rtVal);
        branchTarget = decPc + 32'd4 + (cpuPkg::word_t'($signed(decInstr.iType.imm16)) << 2);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wbWe && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_ff @(posedge clk) begin
        exImm    <= imm;
        exRsVal  <= rsVal;
        exRtVal  <= rtVal;
        exRs     <= decRs;
        exRt     <= decRt;
        exDst    <= dst;
        exPc     <= decPc;
        exAluOp  <= aluOp;
        exUseImm <= useImm;
        if (!rstN || stall) begin
            exKind <= cpuPkg::kNop;      // Bubble
            exWe   <= 1'b0;
        end else begin
            exKind <= decKind;
            exWe   <= writes && dst != '0;  // Writes to r0 die here
        end
    end

    // Writeback arrives three stages later and must never target r0
    noWriteR0: assert property (@(posedge clk) disable iff (!rstN) wbWe |-> wbAddr != '0);

endmodule

`default_nettype wire

// ==== rtl/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire cpuPkg::instrKind_t exKind,
    input  wire cpuPkg::aluOp_t     exAluOp,
    input  wire                     exUseImm,
    input  wire cpuPkg::word_t      exImm,
    input  wire cpuPkg::word_t      exRsVal,
    input  wire cpuPkg::word_t      exRtVal,
    input  wire cpuPkg::regAddr_t   exRs,
    input  wire cpuPkg::regAddr_t   exRt,
    input  wire cpuPkg::regAddr_t   exDst,
    input  wire                     exWe,
    input  wire cpuPkg::word_t      exPc,
    input  wire                     memFwdWe,
    input  wire cpuPkg::regAddr_t   memFwdAddr,
    input  wire cpuPkg::word_t      memFwdData,
    input  wire                     wbWe,
    input  wire cpuPkg::regAddr_t   wbAddr,
    input  wire cpuPkg::word_t      wbData,
    output cpuPkg::instrKind_t      memKind,
    output cpuPkg::word_t           memAluRes,
    output cpuPkg::word_t           memStoreVal,
    output cpuPkg::regAddr_t        memRt,      // For store-data bypass
    output cpuPkg::regAddr_t        memDst,
    output logic                    memWe,
    output cpuPkg::word_t           memPc
);

    cpuPkg::word_t srcA;
    cpuPkg::word_t srcB;
    cpuPkg::word_t rtFwd;   // Also the store value
    cpuPkg::word_t aluRes;

    function automatic cpuPkg::word_t fwd(cpuPkg::regAddr_t a, cpuPkg::word_t regVal);
        if (a != '0 && memFwdWe && memFwdAddr == a)
            return memFwdData;      // Youngest producer wins
        if (a != '0 && wbWe && wbAddr == a)
            return wbData;
        return regVal;
    endfunction

    always_comb begin
        srcA  = fwd(exRs, exRsVal);
        rtFwd = fwd(exRt, exRtVal);
        srcB  = exUseImm ? exImm : rtFwd;
        case (exAluOp)
            cpuPkg::aluSub: aluRes = srcA - srcB;
            cpuPkg::aluAnd: aluRes = srcA & srcB;
            cpuPkg::aluOr:  aluRes = srcA | srcB;
            cpuPkg::aluSlt: aluRes = cpuPkg::word_t'($signed(srcA) < $signed(srcB));
            cpuPkg::aluLui: aluRes = srcB << 16;     // Immediate to upper half
            default:        aluRes = srcA + srcB;    // addu, addiu, lw, sw
        endcase
    end

    always_ff @(posedge clk) begin
        memAluRes   <= aluRes;
        memStoreVal <= rtFwd;
        memRt       <= exRt;
        memDst      <= exDst;
        memPc       <= exPc;
        if (!rstN) begin
            memKind <= cpuPkg::kNop;
            memWe   <= 1'b0;
        end else begin
            memKind <= exKind;
            memWe   <= exWe;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/memWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none

module memWriteback (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire cpuPkg::instrKind_t memKind,
    input  wire cpuPkg::word_t      memAluRes,   // Address for lw/sw
    input  wire cpuPkg::word_t      memStoreVal,
    input  wire cpuPkg::regAddr_t   memRt,
    input  wire cpuPkg::regAddr_t   memDst,
    input  wire                     memWe,
    input  wire cpuPkg::word_t      memPc,
    input  wire cpuPkg::word_t      dataRdata,   // Same-cycle DM answer
    output cpuPkg::word_t           dataAddr,
    output cpuPkg::word_t           dataWdata,
    output logic                    dataWe,
    output logic                    regWe,
    output cpuPkg::regAddr_t        regAddr,
    output cpuPkg::word_t           regWdata,
    output cpuPkg::word_t           wbPc
);

    cpuPkg::word_t wbVal;   // Load data or ALU result

    assign dataAddr  = memAluRes;
    assign dataWe    = memKind == cpuPkg::kSw;
    assign dataWdata = (regWe && regAddr == memRt) ? regWdata : memStoreVal;  // lw then sw
    assign wbVal     = (memKind == cpuPkg::kLw) ? dataRdata : memAluRes;

    always_ff @(posedge clk) begin
        regWdata <= wbVal;
        regAddr  <= memDst;
        wbPc     <= memPc;
        if (!rstN)
            regWe <= 1'b0;
        else
            regWe <= memWe;
    end

    // Word accesses only
    storeAligned: assert property (@(posedge clk) disable iff (!rstN)
        dataWe |-> dataAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire cpuPkg::instrKind_t decKind,
    input  wire cpuPkg::regAddr_t   decRs,
    input  wire cpuPkg::regAddr_t   decRt,
    input  wire cpuPkg::instrKind_t exKind,
    input  wire cpuPkg::regAddr_t   exDst,
    input  wire                     exWe,
    input  wire cpuPkg::instrKind_t memKind,
    input  wire cpuPkg::regAddr_t   memDst,
    input  wire                     memWe,
    output logic                    stall
);

    cpuPkg::stage_t tuseRs;    // 3 means no use
    cpuPkg::stage_t tuseRt;
    cpuPkg::stage_t exTnew;
    cpuPkg::stage_t memTnew;
    logic           isBranch;

    function automatic logic mustWait(cpuPkg::regAddr_t dst, logic we, cpuPkg::stage_t tnew);
        if (!we || dst == '0)
            return 1'b0;
        return (dst == decRs && tnew > tuseRs) || (dst == decRt && tnew > tuseRt);
    endfunction

    always_comb begin
        isBranch = decKind inside {cpuPkg::kBeq, cpuPkg::kBne};
        tuseRs   = (decKind inside {cpuPkg::kNop, cpuPkg::kLui}) ? 2'd3
                 : isBranch ? 2'd0 : 2'd1;
        tuseRt   = isBranch ? 2'd0
                 : (decKind == cpuPkg::kSw) ? 2'd2     // Store data needed in memory
                 : (decKind inside {cpuPkg::kAddu, cpuPkg::kSubu, cpuPkg::kAnd,
                                    cpuPkg::kOr, cpuPkg::kSlt}) ? 2'd1
                 : 2'd3;                               // rt is a destination
        exTnew   = (exKind == cpuPkg::kLw) ? 2'd2 : 2'd1;
        memTnew  = (memKind == cpuPkg::kLw) ? 2'd1 : 2'd0;
        stall    = mustWait(exDst, exWe, exTnew) || mustWait(memDst, memWe, memTnew);
    end

    // Only a branch right behind a load waits a second cycle, and never a third
    shortStall: assert property (@(posedge clk) disable iff (!rstN)
        stall && $past(stall) |-> isBranch && !$past(stall, 2));

endmodule

`default_nettype wire

// ==== rtl/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire                clk,
    input  wire                rstN,
    output cpuPkg::word_t      instAddr,
    input  wire cpuPkg::word_t instRdata,
    output cpuPkg::word_t      dataAddr,
    output cpuPkg::word_t      dataWdata,
    output logic               dataWe,
    input  wire cpuPkg::word_t dataRdata,
    output logic               regWe,       // Write trace, also GRF write port
    output cpuPkg::regAddr_t   regAddr,
    output cpuPkg::word_t      regWdata,
    output cpuPkg::word_t      wbPc
);

    logic               stall;
    logic               branchTaken;
    cpuPkg::word_t      branchTarget;
    cpuPkg::instr_t     decInstr;
    cpuPkg::word_t      decPc;
    cpuPkg::instrKind_t decKind;
    cpuPkg::regAddr_t   decRs;
    cpuPkg::regAddr_t   decRt;
    cpuPkg::instrKind_t exKind;
    cpuPkg::aluOp_t     exAluOp;
    logic               exUseImm;
    cpuPkg::word_t      exImm;
    cpuPkg::word_t      exRsVal;
    cpuPkg::word_t      exRtVal;
    cpuPkg::regAddr_t   exRs;
    cpuPkg::regAddr_t   exRt;
    cpuPkg::regAddr_t   exDst;
    logic               exWe;
    cpuPkg::word_t      exPc;
    cpuPkg::instrKind_t memKind;
    cpuPkg::word_t      memAluRes;
    cpuPkg::word_t      memStoreVal;
    cpuPkg::regAddr_t   memRt;
    cpuPkg::regAddr_t   memDst;
    logic               memWe;
    cpuPkg::word_t      memPc;
    logic               memFwdWe;

    assign memFwdWe = memWe && memKind != cpuPkg::kLw;  // Load data not ready yet

    fetchStage fetch0 (.clk, .rstN, .stall, .branchTaken, .branchTarget,
                       .instRdata, .instAddr, .decInstr, .decPc);

    decodeStage decode0 (.clk, .rstN, .stall, .decInstr, .decPc,
                         .wbWe(regWe), .wbAddr(regAddr), .wbData(regWdata),
                         .memFwdWe, .memFwdAddr(memDst), .memFwdData(memAluRes),
                         .branchTaken, .branchTarget, .decKind, .decRs, .decRt,
                         .exKind, .exAluOp, .exUseImm, .exImm, .exRsVal, .exRtVal,
                         .exRs, .exRt, .exDst, .exWe, .exPc);

    executeStage execute0 (.clk, .rstN, .exKind, .exAluOp, .exUseImm, .exImm,
                           .exRsVal, .exRtVal, .exRs, .exRt, .exDst, .exWe, .exPc,
                           .memFwdWe, .memFwdAddr(memDst), .memFwdData(memAluRes),
                           .wbWe(regWe), .wbAddr(regAddr), .wbData(regWdata),
                           .memKind, .memAluRes, .memStoreVal, .memRt, .memDst,
                           .memWe, .memPc);

    memWriteback memWb0 (.clk, .rstN, .memKind, .memAluRes, .memStoreVal, .memRt,
                         .memDst, .memWe, .memPc, .dataRdata, .dataAddr, .dataWdata,
                         .dataWe, .regWe, .regAddr, .regWdata, .wbPc);

    hazardUnit hazard0 (.clk, .rstN, .decKind, .decRs, .decRt, .exKind, .exDst,
                        .exWe, .memKind, .memDst, .memWe, .stall);

endmodule

`default_nettype wire

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuTb;

    localparam int            PROG_LEN     = 200;        // Random instructions
    localparam int            CLK_PERIOD   = 4;
    localparam int            RESET_CYCLES = 16;
    localparam int            TIMEOUT_NS   = (PROG_LEN * 4 + 100) * CLK_PERIOD;
    localparam int unsigned   SEED         = 32'hb28f_4c20;
    localparam cpuPkg::word_t LOOP_ADDR    = `CPU_RESET_PC + PROG_LEN * 4;  // Final self-loop

    logic             clk = 1'b0;
    logic             rstN;
    cpuPkg::word_t    instAddr;
    cpuPkg::word_t    instRdata;
    cpuPkg::word_t    dataAddr;
    cpuPkg::word_t    dataWdata;
    logic             dataWe;
    cpuPkg::word_t    dataRdata;
    logic             regWe;
    cpuPkg::regAddr_t regAddr;
    cpuPkg::word_t    regWdata;
    cpuPkg::word_t    wbPc;

    cpuPkg::word_t    imem [0:255];      // Program, nop beyond its end
    cpuPkg::word_t    dmem [0:63];       // 256 bytes of data
    cpuPkg::regAddr_t expRegAddr [0:255];
    cpuPkg::word_t    expRegData [0:255];
    cpuPkg::word_t    expRegPc   [0:255];
    cpuPkg::word_t    expStAddr  [0:255];
    cpuPkg::word_t    expStData  [0:255];
    int               expWrites;
    int               expStores;
    int               gotWrites = 0;
    int               gotStores = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpuCore dut0 (.clk, .rstN, .instAddr, .instRdata, .dataAddr, .dataWdata, .dataWe,
                  .dataRdata, .regWe, .regAddr, .regWdata, .wbPc);

    function automatic cpuPkg::word_t fetchWord(cpuPkg::word_t addr);
        cpuPkg::word_t off;
        off = addr - `CPU_RESET_PC;     // Below reset PC wraps high
        if (off < 32'd1024)
            return imem[off[9:2]];
        return '0;
    endfunction

    assign instRdata = fetchWord(instAddr);
    assign dataRdata = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (!rstN)
            dmem <= '{default: '0};
        else if (dataWe)
            dmem[dataAddr[7:2]] <= dataWdata;
    end

    task automatic failRun(input string why);
        if (why != "")
            $display("ERROR at %0t: %s", $time, why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic reportMismatch(input string name, input cpuPkg::word_t got,
                                  input cpuPkg::word_t exp);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        failRun("");
    endtask

    task automatic checkFetchAddr(input cpuPkg::word_t got, input cpuPkg::word_t exp);
        if (got !== exp)
            reportMismatch("instAddr", got, exp);
    endtask

    task automatic checkRegWrite(input cpuPkg::regAddr_t gotAddr,
                                 input cpuPkg::regAddr_t expAddr,
                                 input cpuPkg::word_t gotData, input cpuPkg::word_t expData,
                                 input cpuPkg::word_t gotPc, input cpuPkg::word_t expPc);
        if (gotPc !== expPc)
            reportMismatch("wbPc", gotPc, expPc);   // Wrong path or order
        else if (gotAddr !== expAddr)
            reportMismatch("regAddr", cpuPkg::word_t'(gotAddr), cpuPkg::word_t'(expAddr));
        else if (gotData !== expData)
            reportMismatch("regWdata", gotData, expData);
    endtask

    task automatic checkStore(input cpuPkg::word_t gotAddr, input cpuPkg::word_t expAddr,
                              input cpuPkg::word_t gotData, input cpuPkg::word_t expData);
        if (gotAddr !== expAddr)
            reportMismatch("dataAddr", gotAddr, expAddr);
        else if (gotData !== expData)
            reportMismatch("dataWdata", gotData, expData);
    endtask

    function automatic cpuPkg::word_t encR(cpuPkg::regAddr_t rs, cpuPkg::regAddr_t rt,
                                           cpuPkg::regAddr_t rd, logic [5:0] funct);
        cpuPkg::instr_t w;
        w             = '0;
        w.rType.op    = `CPU_OP_RTYPE;
        w.rType.rs    = rs;
        w.rType.rt    = rt;
        w.rType.rd    = rd;
        w.rType.funct = funct;
        return w;
    endfunction

    function automatic cpuPkg::word_t encI(logic [5:0] op, cpuPkg::regAddr_t rs,
                                           cpuPkg::regAddr_t rt, logic [15:0] imm16);
        cpuPkg::instr_t w;
        w.iType.op    = op;
        w.iType.rs    = rs;
        w.iType.rt    = rt;
        w.iType.imm16 = imm16;
        return w;
    endfunction

    function automatic cpuPkg::regAddr_t pickReg();
        int unsigned r;
        r = $urandom;
        return {2'b00, r[2:0]};         // r0..r7 keeps dependencies dense
    endfunction

    task automatic genProgram();
        int unsigned      r;
        int unsigned      sel;
        int               off;
        logic             inSlot;
        cpuPkg::word_t    w;
        cpuPkg::regAddr_t rs;
        cpuPkg::regAddr_t rt;
        cpuPkg::regAddr_t rd;
        imem   = '{default: '0};
        inSlot = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            r   = $urandom;
            sel = r % 32'd12;
            if (sel >= 32'd10 && (inSlot || i == PROG_LEN - 1))
                sel = 32'd0;            // No branch in a delay slot
            rs  = pickReg();
            rt  = pickReg();
            rd  = pickReg();
            r   = $urandom;             // Fresh bits for the immediate
            case (sel)
                0:       w = encR(rs, rt, rd, `CPU_FN_ADDU);
                1:       w = encR(rs, rt, rd, `CPU_FN_SUBU);
                2:       w = encR(rs, rt, rd, `CPU_FN_AND);
                3:       w = encR(rs, rt, rd, `CPU_FN_OR);
                4:       w = encR(rs, rt, rd, `CPU_FN_SLT);
                5:       w = encI(`CPU_OP_ADDIU, rs, rt, r[15:0]);
                6:       w = encI(`CPU_OP_ORI, rs, rt, r[15:0]);
                7:       w = encI(`CPU_OP_LUI, '0, rt, r[15:0]);
                8:       w = encI(`CPU_OP_LW, '0, rt, {8'h00, r[5:0], 2'b00});
                9:       w = encI(`CPU_OP_SW, '0, rt, {8'h00, r[5:0], 2'b00});
                default: begin
                    off = 1 + int'(r % 32'd4);
                    if (i + 1 + off > PROG_LEN)
                        off = PROG_LEN - 1 - i;     // Final loop at the farthest
                    w = encI((sel == 32'd10) ? `CPU_OP_BEQ : `CPU_OP_BNE, rs, rt, off[15:0]);
                end
            endcase
            imem[i[7:0]] = w;
            inSlot       = sel >= 32'd10;
        end
        imem[PROG_LEN] = encI(`CPU_OP_BEQ, '0, '0, 16'hffff);  // Self-loop, nop follows
    endtask

    // Sequential ISA model with one delay slot that records every result in order
    task automatic runModel();
        cpuPkg::word_t    mreg [0:31];
        cpuPkg::word_t    mmem [0:63];
        cpuPkg::instr_t   ins;
        cpuPkg::word_t    pc;
        cpuPkg::word_t    npc;
        cpuPkg::word_t    nnpc;
        cpuPkg::word_t    a;
        cpuPkg::word_t    b;
        cpuPkg::word_t    sImm;
        cpuPkg::word_t    addr;
        cpuPkg::word_t    res;
        cpuPkg::regAddr_t dst;
        logic             wr;
        int               steps;
        mreg      = '{default: '0};
        mmem      = '{default: '0};
        expWrites = 0;
        expStores = 0;
        pc        = `CPU_RESET_PC;
        npc       = `CPU_RESET_PC + 32'd4;
        steps     = 0;
        while (pc != LOOP_ADDR && steps < 4 * PROG_LEN) begin
            ins  = fetchWord(pc);
            a    = mreg[ins.rType.rs];
            b    = mreg[ins.rType.rt];
            sImm = {{16{ins.iType.imm16[15]}}, ins.iType.imm16};
            addr = a + sImm;
            nnpc = npc + 32'd4;
            dst  = ins.iType.rt;
            wr   = 1'b1;
            res  = '0;
            case (ins.rType.op)
                `CPU_OP_RTYPE: begin
                    dst = ins.rType.rd;
                    case (ins.rType.funct)
                        `CPU_FN_ADDU: res = a + b;
                        `CPU_FN_SUBU: res = a - b;
                        `CPU_FN_AND:  res = a & b;
                        `CPU_FN_OR:   res = a | b;
                        `CPU_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:      wr  = 1'b0;   // sll 0 is the nop
                    endcase
                end
                `CPU_OP_ADDIU: res = addr;
                `CPU_OP_ORI:   res = a | {16'h0000, ins.iType.imm16};
                `CPU_OP_LUI:   res = {ins.iType.imm16, 16'h0000};
                `CPU_OP_LW:    res = mmem[addr[7:2]];
                `CPU_OP_SW: begin
                    wr                        = 1'b0;
                    mmem[addr[7:2]]           = b;
                    expStAddr[expStores[7:0]] = addr;
                    expStData[expStores[7:0]] = b;
                    expStores++;
                end
                `CPU_OP_BEQ, `CPU_OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (ins.rType.op == `CPU_OP_BEQ))
                        nnpc = pc + 32'd4 + {sImm[29:0], 2'b00};  // After the slot
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                mreg[dst]                  = res;
                expRegAddr[expWrites[7:0]] = dst;
                expRegData[expWrites[7:0]] = res;
                expRegPc[expWrites[7:0]]   = pc;
                expWrites++;
            end
            pc  = npc;
            npc = nnpc;
            steps++;
        end
        if (pc != LOOP_ADDR)
            failRun("reference model never reached the final loop");
    endtask

    // Trace monitor sampling mid-cycle
    always @(negedge clk) begin
        if (!rstN) begin
            if (regWe !== 1'b0 || dataWe !== 1'b0)
                failRun("regWe or dataWe active during reset");
        end else begin
            if (regWe) begin
                if (regAddr == '0)
                    failRun("register write to r0 seen on the trace");
                else if (gotWrites >= expWrites)
                    failRun("register write after the last one the model expects");
                else begin
                    checkRegWrite(regAddr, expRegAddr[gotWrites[7:0]],
                                  regWdata, expRegData[gotWrites[7:0]],
                                  wbPc, expRegPc[gotWrites[7:0]]);
                    gotWrites++;
                end
            end
            if (dataWe) begin
                if (gotStores >= expStores)
                    failRun("store after the last one the model expects");
                else begin
                    checkStore(dataAddr, expStAddr[gotStores[7:0]],
                               dataWdata, expStData[gotStores[7:0]]);
                    gotStores++;
                end
            end
        end
    end

    initial begin
        rstN = 1'b0;
        void'($urandom(SEED));
        genProgram();
        runModel();
        $display("Program of %0d words, model expects %0d writes and %0d stores",
                 PROG_LEN + 2, expWrites, expStores);
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstN = 1'b1;
        @(negedge clk);
        checkFetchAddr(instAddr, `CPU_RESET_PC);
        while (wbPc !== LOOP_ADDR)
            @(negedge clk);             // Loop in writeback, all older ones retired
        if (gotWrites == expWrites && gotStores == expStores) begin
            $display("Saw %0d writes and %0d stores", gotWrites, gotStores);
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Saw %0d of %0d writes and %0d of %0d stores",
                     gotWrites, expWrites, gotStores, expStores);
            failRun("result count differs from the model");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        failRun("timeout, the program never reached its final loop");
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWriteback.sv
rtl/hazardUnit.sv
rtl/cpuCore.sv
dv/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module cpuTb -o cpuTbSim

out=$(./obj_dir/cpuTbSim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1
